//--- src/dbg_pkg.sv
package dbg_pkg;

    // Core word width and the number of bytes in one reply word
    localparam int XLEN = 32;
    localparam int REPLY_BYTES = XLEN / 8;

    // Command codes the host sends as the first byte of a transaction
    typedef enum logic [7:0] {
        CMD_NOP           = 8'h00,
        CMD_ECHO          = 8'h01,
        CMD_TOGGLE_LED    = 8'h02,
        CMD_ENABLE_CLOCK  = 8'h03,
        CMD_DISABLE_CLOCK = 8'h04,
        CMD_STEP_CLOCK    = 8'h05,
        CMD_GET_PC        = 8'h06,
        CMD_GET_REG       = 8'h07,
        CMD_READ_FLASH    = 8'h08,
        CMD_ECHO_CC       = 8'hCC
    } dbg_cmd_e;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ECHO,
        ST_READ_REG,
        ST_REPLYING
    } dbg_state_e;

    // Received byte with its one-cycle strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } spi_rx_t;

    // Debug view of the core
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] reg_data;
    } core_dbg_t;

endpackage

//--- src/spi_slave.sv
`timescale 1ns/10ps

module spi_slave (
    input  logic             clk,
    input  logic             rst,
    input  logic             sclk,
    input  logic             mosi,
    input  logic             ss,
    output logic             miso,
    input  logic [7:0]       tx_byte,
    output dbg_pkg::spi_rx_t rx
);
    import dbg_pkg::*;

    logic [2:0] sclk_q;    // Two sync stages plus one for edge detection
    logic [2:0] ss_q;
    logic [1:0] mosi_q;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       ss_fall;
    logic       ss_active;
    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic       byte_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_q <= '0;
            ss_q   <= '1;      // Deselected while in reset
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], sclk};
            ss_q   <= {ss_q[1:0], ss};
            mosi_q <= {mosi_q[0], mosi};
        end
    end

    assign ss_active = ~ss_q[1];
    assign sclk_rise = sclk_q[1] & ~sclk_q[2] & ss_active;
    assign sclk_fall = ~sclk_q[1] & sclk_q[2] & ss_active;
    assign ss_fall   = ~ss_q[1] & ss_q[2];

    // Receive side counts rising edges and flags the eighth
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (!ss_active) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    byte_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_q[1]};    // MSB arrives first
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx.valid <= 1'b0;
        end else begin
            rx.valid <= byte_done;
        end
        rx.data <= rx_shift;
    end

    // A new byte is loaded when the slave is selected or when the previous byte ends
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_shift <= '0;
        end else if (ss_fall) begin
            tx_shift <= tx_byte;
        end else if (sclk_fall) begin
            if (bit_cnt == 3'd0) begin
                tx_shift <= tx_byte;    // Falling edge after the eighth bit
            end else begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    assign miso = tx_shift[7];

endmodule

//--- src/dbg_cmd_ctrl.sv
`timescale 1ns/10ps

module dbg_cmd_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  dbg_pkg::spi_rx_t   rx,
    input  dbg_pkg::core_dbg_t core,
    output logic [7:0]         tx_byte,
    output logic [4:0]         reg_sel,
    output logic               core_ce,
    output logic               led
);
    import dbg_pkg::*;

    localparam int CNT_W = $clog2(REPLY_BYTES + 1);

    dbg_state_e       state;
    dbg_cmd_e         cmd;
    logic [XLEN-1:0]  word_buf;
    logic [CNT_W-1:0] bytes_left;
    logic             load_reg;    // Register read data is valid one cycle after reg_sel
    logic             run;
    logic             step;

    assign cmd     = dbg_cmd_e'(rx.data);
    assign core_ce = run | step;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            tx_byte    <= '0;
            bytes_left <= '0;
            load_reg   <= 1'b0;
            run        <= 1'b0;
            step       <= 1'b0;
            led        <= 1'b0;
        end else begin
            step     <= 1'b0;
            load_reg <= 1'b0;
            if (rx.valid) begin
                case (state)
                    ST_IDLE: begin
                        tx_byte <= 8'h00;
                        case (cmd)
                            CMD_NOP: begin
                            end
                            CMD_ECHO: begin
                                tx_byte <= CMD_ECHO;
                                state   <= ST_ECHO;
                            end
                            CMD_TOGGLE_LED: begin
                                led <= ~led;
                            end
                            CMD_ENABLE_CLOCK: begin
                                run <= 1'b1;
                            end
                            CMD_DISABLE_CLOCK: begin
                                run <= 1'b0;
                            end
                            CMD_STEP_CLOCK: begin
                                step <= 1'b1;    // Exactly one enabled core cycle
                            end
                            CMD_GET_PC: begin
                                tx_byte    <= 8'(REPLY_BYTES);
                                bytes_left <= CNT_W'(REPLY_BYTES);
                                state      <= ST_REPLYING;
                            end
                            CMD_GET_REG: begin
                                state <= ST_READ_REG;
                            end
                            CMD_READ_FLASH: begin
                                tx_byte <= 8'hFF;    // No flash behind this port
                            end
                            CMD_ECHO_CC: begin
                                tx_byte <= 8'hCC;
                            end
                            default: begin
                                tx_byte <= 8'hFF;
                            end
                        endcase
                    end
                    ST_ECHO: begin
                        tx_byte <= rx.data;
                        state   <= ST_IDLE;
                    end
                    ST_READ_REG: begin
                        tx_byte    <= 8'h00;
                        bytes_left <= CNT_W'(REPLY_BYTES);
                        load_reg   <= 1'b1;
                        state      <= ST_REPLYING;
                    end
                    ST_REPLYING: begin
                        tx_byte    <= word_buf[XLEN-1 -: 8];
                        bytes_left <= bytes_left - CNT_W'(1);
                        if (bytes_left == CNT_W'(1)) begin
                            state <= ST_IDLE;
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // Reply word, sent most significant byte first
    always_ff @(posedge clk) begin
        if (load_reg) begin
            word_buf <= core.reg_data;
        end else if (rx.valid && state == ST_IDLE && cmd == CMD_GET_PC) begin
            word_buf <= core.pc;
        end else if (rx.valid && state == ST_REPLYING) begin
            word_buf <= {word_buf[XLEN-9:0], 8'h00};
        end
        if (rx.valid && state == ST_READ_REG) begin
            reg_sel <= rx.data[4:0];
        end
    end

endmodule

//--- src/trace_core.sv
`timescale 1ns/10ps

module trace_core #(
    parameter logic [dbg_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ce,
    input  logic [4:0]         reg_sel,
    output dbg_pkg::core_dbg_t dbg
);
    import dbg_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] regs [32];
    logic [4:0]      wr_idx;

    // Word index of the pc selects the register it lands in
    assign wr_idx = pc[6:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ce) begin
            regs[wr_idx] <= pc;
            pc           <= pc + XLEN'(4);
        end
    end

    assign dbg.pc       = pc;
    assign dbg.reg_data = regs[reg_sel];

endmodule

//--- src/spi_dbg_soc.sv
`timescale 1ns/10ps

module spi_dbg_soc #(
    parameter logic [dbg_pkg::XLEN-1:0] RESET_PC = 32'h0000_0100
) (
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic mosi,
    input  logic ss,
    output logic miso,
    output logic led
);
    import dbg_pkg::*;

    spi_rx_t    rx;
    core_dbg_t  core_dbg;
    logic [7:0] tx_byte;
    logic [4:0] reg_sel;
    logic       core_ce;

    spi_slave spi0 (
        .clk     (clk),
        .rst     (rst),
        .sclk    (sclk),
        .mosi    (mosi),
        .ss      (ss),
        .miso    (miso),
        .tx_byte (tx_byte),
        .rx      (rx)
    );

    dbg_cmd_ctrl ctrl0 (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .core    (core_dbg),
        .tx_byte (tx_byte),
        .reg_sel (reg_sel),
        .core_ce (core_ce),
        .led     (led)
    );

    trace_core #(
        .RESET_PC (RESET_PC)
    ) core0 (
        .clk     (clk),
        .rst     (rst),
        .ce      (core_ce),
        .reg_sel (reg_sel),
        .dbg     (core_dbg)
    );

endmodule

//--- test/spi_host_tasks.svh
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

task automatic wait_cycles(input int count);
    for (int i = 0; i < count; i++) begin
        @(negedge clk);
    end
endtask

// SPI mode 0 host, MSB first; miso is sampled just before each rising sclk edge
task automatic transfer_byte(input logic [7:0] value, output logic [7:0] got);
    @(negedge clk);
    ss = 1'b0;
    for (int i = 7; i >= 0; i--) begin
        mosi = value[i];
        wait_cycles(HALF_BIT);
        got[i] = miso;
        sclk   = 1'b1;
        wait_cycles(HALF_BIT);
        sclk = 1'b0;
    end
    wait_cycles(HALF_BIT);
    ss = 1'b1;
    wait_cycles(FRAME_GAP);
endtask

task automatic check_byte(input string name, input logic [7:0] expected, input logic [7:0] actual);
    if (actual !== expected) begin
        $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
        abort_run("Stopped at the first wrong reply byte");
    end
endtask

task automatic check_led(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("[ERROR] %s: expected led %b, actual led %b", name, expected, actual);
        abort_run("Stopped at the first wrong LED level");
    end
endtask

task automatic check_word(input string name, input logic [XLEN-1:0] expected,
                          input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
        $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        abort_run("Stopped at the first wrong word");
    end
endtask

task automatic wait_led(input string name, input logic expected);
    int waited;
    waited = 0;
    while (led !== expected && waited < LED_TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    check_led(name, expected, led);
endtask

`endif

//--- test/tb_spi_dbg_soc.sv
`timescale 1ns/10ps

module tb_spi_dbg_soc;
    import dbg_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;
    localparam int MAX_ROWS    = 128;
    localparam int N_STEPS     = 6;
    localparam int HALF_BIT    = 8;    // clk cycles per sclk phase
    localparam int FRAME_GAP   = 8;
    localparam int LED_TIMEOUT = 40;

    typedef struct packed {
        logic [7:0] data;     // Byte sent by the host
        logic [7:0] reply;    // Expected on miso during the following byte
        logic       check;    // Reply is known before the run
        logic       led;
    } row_t;

    logic       clk;
    logic       rst;
    logic       sclk;
    logic       mosi;
    logic       ss;
    logic       miso;
    logic       led;
    row_t       rows [MAX_ROWS];
    string      row_name [MAX_ROWS];
    logic [7:0] reply_log [MAX_ROWS];
    int         n_rows;
    int         run_read_a;
    int         run_read_b;
    logic       led_model;

    spi_dbg_soc #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .clk  (clk),
        .rst  (rst),
        .sclk (sclk),
        .mosi (mosi),
        .ss   (ss),
        .miso (miso),
        .led  (led)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("TEST FAIL");
        $fatal(1, "%s", reason);
    endtask

    `include "spi_host_tasks.svh"

    function automatic logic [XLEN-1:0] model_pc(input int steps);
        return RESET_PC + XLEN'(4 * steps);
    endfunction

    // Replays the trace rule from reset and returns one register
    function automatic logic [XLEN-1:0] model_reg(input int sel, input int steps);
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] regs [32];
        logic [4:0]      idx;
        pc = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int s = 0; s < steps; s++) begin
            idx       = 5'((pc / 4) % 32);
            regs[idx] = pc;
            pc        = pc + 4;
        end
        return regs[sel];
    endfunction

    task automatic add_row(input string name, input logic [7:0] value, input logic [7:0] expected,
                           input logic known);
        if (n_rows == MAX_ROWS) begin
            abort_run("The stimulus table is full");
        end else begin
            rows[n_rows]     = '{data: value, reply: expected, check: known, led: led_model};
            row_name[n_rows] = name;
            n_rows++;
        end
    endtask

    // Random filler bytes that clock out a word with the most significant byte first
    task automatic add_word_rows(input string name, input logic [XLEN-1:0] word, input logic known);
        for (int b = 0; b < REPLY_BYTES; b++) begin
            add_row($sformatf("%s byte %0d", name, b), 8'($urandom), word[XLEN-1-8*b -: 8], known);
        end
    endtask

    task automatic build_table();
        logic [7:0] value;
        add_row("nop", CMD_NOP, 8'h00, 1'b1);
        add_row("echo_cc", CMD_ECHO_CC, 8'hCC, 1'b1);
        add_row("read_flash", CMD_READ_FLASH, 8'hFF, 1'b1);
        add_row("unknown code", 8'h5A, 8'hFF, 1'b1);
        for (int i = 0; i < 4; i++) begin
            value = 8'($urandom);
            add_row("echo", CMD_ECHO, 8'h01, 1'b1);
            add_row("echo data", value, value, 1'b1);
        end
        led_model = 1'b1;
        add_row("led on", CMD_TOGGLE_LED, 8'h00, 1'b1);
        led_model = 1'b0;
        add_row("led off", CMD_TOGGLE_LED, 8'h00, 1'b1);
        add_row("pc before steps", CMD_GET_PC, 8'(REPLY_BYTES), 1'b1);
        add_word_rows("pc before steps", model_pc(0), 1'b1);
        for (int s = 0; s < N_STEPS; s++) begin
            add_row("step", CMD_STEP_CLOCK, 8'h00, 1'b1);
        end
        add_row("pc after steps", CMD_GET_PC, 8'(REPLY_BYTES), 1'b1);
        add_word_rows("pc after steps", model_pc(N_STEPS), 1'b1);
        for (int k = 0; k < N_STEPS; k++) begin
            add_row("get_reg", CMD_GET_REG, 8'h00, 1'b1);
            add_row("reg select", {3'($urandom), 5'(k)}, 8'h00, 1'b1);    // Upper bits ignored
            add_word_rows($sformatf("reg %0d", k), model_reg(k, N_STEPS), 1'b1);
        end
        add_row("run", CMD_ENABLE_CLOCK, 8'h00, 1'b1);
        add_row("nop while running", CMD_NOP, 8'h00, 1'b1);
        add_row("stop", CMD_DISABLE_CLOCK, 8'h00, 1'b1);
        add_row("pc read a", CMD_GET_PC, 8'(REPLY_BYTES), 1'b1);
        run_read_a = n_rows;
        add_word_rows("pc read a", '0, 1'b0);
        add_row("pc read b", CMD_GET_PC, 8'(REPLY_BYTES), 1'b1);
        run_read_b = n_rows;
        add_word_rows("pc read b", '0, 1'b0);
        add_row("final nop", CMD_NOP, 8'h00, 1'b0);
    endtask

    task automatic run_table();
        logic [7:0] got;
        for (int i = 0; i < n_rows; i++) begin
            transfer_byte(rows[i].data, got);
            if (i > 0) begin
                reply_log[i-1] = got;    // What arrives now answers the previous byte
                if (rows[i-1].check) begin
                    check_byte(row_name[i-1], rows[i-1].reply, got);
                end
            end
            wait_led(row_name[i], rows[i].led);
        end
    endtask

    task automatic check_run_reads();
        logic [XLEN-1:0] word_a;
        logic [XLEN-1:0] word_b;
        word_a = '0;
        word_b = '0;
        for (int b = 0; b < REPLY_BYTES; b++) begin
            word_a = {word_a[XLEN-9:0], reply_log[run_read_a + b]};
            word_b = {word_b[XLEN-9:0], reply_log[run_read_b + b]};
        end
        check_word("pc reads after stop", word_a, word_b);
        if (word_a <= model_pc(N_STEPS)) begin
            $display("[ERROR] pc after run: expected above 0x%08h, actual 0x%08h",
                     model_pc(N_STEPS), word_a);
            abort_run("The program counter did not advance while the core clock was enabled");
        end
    endtask

    initial begin
        void'($urandom(32'h33ec09f3));
        rst        = 1'b1;
        sclk       = 1'b0;
        mosi       = 1'b0;
        ss         = 1'b1;
        n_rows     = 0;
        run_read_a = 0;
        run_read_b = 0;
        led_model  = 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_cycles(FRAME_GAP);
        run_table();
        check_run_reads();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- sim.f
+incdir+test
src/dbg_pkg.sv
src/spi_slave.sv
src/dbg_cmd_ctrl.sv
src/trace_core.sv
src/spi_dbg_soc.sv
test/tb_spi_dbg_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_spi_dbg_soc -f sim.f -Mdir obj_dir -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
